//--- axi_mem.f
+incdir+hw
hw/axi_mem_pkg.sv
hw/axi_mem_req_fifo.sv
hw/axi_mem_array.sv
hw/axi_mem_write_engine.sv
hw/axi_mem_read_engine.sv
hw/axi_mem.sv
test/tb_axi_mem.sv

//--- run_sim.sh
#!/bin/sh
# build the axi_mem testbench with Verilator and run it
# the exit status of the simulation is the result of the run
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_axi_mem \
   -f axi_mem.f \
   -o tb_axi_mem

./obj_dir/tb_axi_mem

//--- test/tb_axi_mem.sv
`timescale 1ns/1ps
`include "axi_mem_macros.svh"

module tb_axi_mem;

   localparam int NUM_TESTS       = 6;
   localparam int CYCLES_PER_TEST = 200;

   logic                       ACLK;
   logic                       ARESETn;
   axi_mem_pkg::axi_ax_t       aw;
   logic                       aw_valid;
   logic                       aw_ready;
   axi_mem_pkg::axi_w_t        w;
   logic                       w_valid;
   logic                       w_ready;
   axi_mem_pkg::axi_b_t        b;
   logic                       b_valid;
   logic                       b_ready;
   axi_mem_pkg::axi_ax_t       ar;
   logic                       ar_valid;
   logic                       ar_ready;
   axi_mem_pkg::axi_r_t        r;
   logic                       r_valid;
   logic                       r_ready;
   integer                     seed;
   logic [7:0]                 model_mem [`AXI_MEM_BYTES];  // byte-wide reference model
   logic [`AXI_MEM_DATA_W-1:0] beat_data [16];  // W beats of the next burst
   logic [`AXI_MEM_STRB_W-1:0] beat_strb [16];

   axi_mem DUT (
      .ACLK, .ARESETn,
      .aw, .aw_valid, .aw_ready,
      .w, .w_valid, .w_ready,
      .b, .b_valid, .b_ready,
      .ar, .ar_valid, .ar_ready,
      .r, .r_valid, .r_ready
   );

   always #4 ACLK = ~ACLK;  // 8 ns period

   // ----------------------------------------------------------
   // reference model, upper address bits ignored
   // ----------------------------------------------------------
   task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
      for (int lane = 0; lane < `AXI_MEM_STRB_W; lane++) begin
         if (strb[lane]) model_mem[{addr[9:2], 2'(lane)}] = data[8*lane +: 8];
      end
   endtask

   function automatic logic [31:0] model_word(input logic [31:0] addr);
      return {model_mem[{addr[9:2], 2'd3}], model_mem[{addr[9:2], 2'd2}],
              model_mem[{addr[9:2], 2'd1}], model_mem[{addr[9:2], 2'd0}]};
   endfunction

   // ----------------------------------------------------------
   // compare tasks
   // ----------------------------------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp) abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
   endtask

   task automatic check_b(input axi_mem_pkg::axi_b_t got, input axi_mem_pkg::axi_b_t exp);
      if (got !== exp) abort_run($sformatf("mismatch b: got %h expected %h", got, exp));
   endtask

   task automatic check_r(input axi_mem_pkg::axi_r_t got, input axi_mem_pkg::axi_r_t exp);
      if (got !== exp) abort_run($sformatf("mismatch r: got %h expected %h", got, exp));
   endtask

   // ----------------------------------------------------------
   // bus tasks, each starts and ends on a falling edge
   // ----------------------------------------------------------
   task automatic send_aw(input logic [7:0] id, input logic [31:0] addr,
                          input logic [7:0] len, input logic [2:0] size);
      aw       = '{id: id, addr: addr, len: len, size: size};
      aw_valid = 1'b1;
      while (!aw_ready) @(negedge ACLK);  // ready is settled since the last rise
      @(negedge ACLK);
      aw_valid = 1'b0;
   endtask

   task automatic send_ar(input logic [7:0] id, input logic [31:0] addr,
                          input logic [7:0] len, input logic [2:0] size);
      ar       = '{id: id, addr: addr, len: len, size: size};
      ar_valid = 1'b1;
      while (!ar_ready) @(negedge ACLK);
      @(negedge ACLK);
      ar_valid = 1'b0;
   endtask

   task automatic write_burst(input logic [7:0] id, input logic [31:0] addr,
                              input logic [7:0] len, input logic [2:0] size);
      axi_mem_pkg::axi_b_t exp_b;
      logic [31:0]         a;
      a = addr;
      send_aw(id, addr, len, size);
      for (int i = 0; i <= int'(len); i++) begin
         w       = '{data: beat_data[i], strb: beat_strb[i], last: (i == int'(len))};
         w_valid = 1'b1;
         while (!w_ready) @(negedge ACLK);
         model_write(a, beat_data[i], beat_strb[i]);
         a = a + (32'd1 << size);  // INCR step
         @(negedge ACLK);
      end
      w_valid = 1'b0;
      b_ready = 1'b1;
      while (!b_valid) @(negedge ACLK);
      exp_b = '{id: id, resp: axi_mem_pkg::OKAY};
      check_b(b, exp_b);
      @(negedge ACLK);
      b_ready = 1'b0;
   endtask

   task automatic collect_r(input logic [7:0] id, input logic [31:0] addr,
                            input logic [7:0] len, input logic [2:0] size,
                            input int max_stall);
      axi_mem_pkg::axi_r_t exp_r;
      logic [31:0]         a;
      int                  stall;
      a = addr;
      for (int i = 0; i <= int'(len); i++) begin
         exp_r = '{id: id, data: model_word(a), resp: axi_mem_pkg::OKAY,
                   last: (i == int'(len))};
         stall = (max_stall > 0) ? int'($unsigned($random(seed)) % max_stall) : 0;
         repeat (stall) begin
            @(negedge ACLK);
            if (r_valid) check_r(r, exp_r);  // must hold under back-pressure
         end
         r_ready = 1'b1;
         while (!r_valid) @(negedge ACLK);
         check_r(r, exp_r);
         @(negedge ACLK);
         r_ready = 1'b0;
         a = a + (32'd1 << size);
      end
   endtask

   // ----------------------------------------------------------
   // directed tests
   // ----------------------------------------------------------
   task automatic test_reset_levels();
      check_level("aw_ready", aw_ready, 1'b1);
      check_level("ar_ready", ar_ready, 1'b1);
      check_level("w_ready", w_ready, 1'b0);
      check_level("b_valid", b_valid, 1'b0);
      check_level("r_valid", r_valid, 1'b0);
   endtask

   task automatic test_single_word();
      beat_data[0] = $random(seed);
      beat_strb[0] = 4'hf;
      write_burst(8'h11, 32'h40, 8'd0, 3'd2);
      send_ar(8'h22, 32'h40, 8'd0, 3'd2);
      collect_r(8'h22, 32'h40, 8'd0, 3'd2, 0);
   endtask

   task automatic test_incr_burst();
      for (int i = 0; i < 8; i++) begin
         beat_data[i] = $random(seed);
         beat_strb[i] = 4'hf;
      end
      write_burst(8'h31, 32'h100, 8'd7, 3'd2);
      send_ar(8'h32, 32'h100, 8'd7, 3'd2);
      collect_r(8'h32, 32'h100, 8'd7, 3'd2, 0);  // rlast only on beat 8
   endtask

   task automatic test_strobes();
      logic [31:0] a;
      beat_data[0] = $random(seed);
      beat_strb[0] = 4'hf;
      write_burst(8'h41, 32'h80, 8'd0, 3'd2);  // known word first
      beat_data[0] = $random(seed);
      beat_strb[0] = 4'b0101;
      write_burst(8'h42, 32'h80, 8'd0, 3'd2);
      send_ar(8'h43, 32'h80, 8'd0, 3'd2);
      collect_r(8'h43, 32'h80, 8'd0, 3'd2, 0);
      beat_data[0] = $random(seed);
      beat_strb[0] = 4'hf;
      write_burst(8'h44, 32'h84, 8'd0, 3'd2);
      // byte beats, lane follows the address
      for (int i = 0; i < 4; i++) begin
         a            = 32'h84 + 32'(i);
         beat_data[i] = $random(seed);
         beat_strb[i] = 4'b0001 << a[1:0];
      end
      write_burst(8'h45, 32'h84, 8'd3, 3'd0);
      send_ar(8'h46, 32'h84, 8'd0, 3'd2);
      collect_r(8'h46, 32'h84, 8'd0, 3'd2, 0);
   endtask

   task automatic test_queued_reads();
      send_ar(8'h51, 32'h100, 8'd1, 3'd2);  // r_ready still low
      send_ar(8'h52, 32'h80, 8'd0, 3'd2);
      send_ar(8'h53, 32'h84, 8'd0, 3'd2);
      collect_r(8'h51, 32'h100, 8'd1, 3'd2, 7);
      collect_r(8'h52, 32'h80, 8'd0, 3'd2, 7);
      collect_r(8'h53, 32'h84, 8'd0, 3'd2, 7);
   endtask

   task automatic test_wrap();
      beat_data[0] = $random(seed);
      beat_strb[0] = 4'hf;
      write_burst(8'h61, 32'h0000_0c20, 8'd0, 3'd2);  // lands on byte 0x20
      send_ar(8'h62, 32'h20, 8'd0, 3'd2);
      collect_r(8'h62, 32'h20, 8'd0, 3'd2, 0);
   endtask

   // watchdog, bounded by the number of tests
   initial begin
      repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge ACLK);
      $display("timeout: a handshake never completed");
      $display("Checks failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      seed     = 32'h5864_19a6;
      ACLK     = 1'b0;
      ARESETn  = 1'b0;
      aw       = '0;
      aw_valid = 1'b0;
      w        = '0;
      w_valid  = 1'b0;
      b_ready  = 1'b0;
      ar       = '0;
      ar_valid = 1'b0;
      r_ready  = 1'b0;
      repeat (5) @(posedge ACLK);
      @(negedge ACLK);
      ARESETn = 1'b1;
      test_reset_levels();
      test_single_word();
      test_incr_burst();
      test_strobes();
      test_queued_reads();
      test_wrap();
      $display("All checks passed");
      $finish;
   end

endmodule

//--- hw/axi_mem.sv
`timescale 1ns/1ps
`include "axi_mem_macros.svh"

// AXI4 slave memory, 1 KiB, queued AW and AR
module axi_mem (
   input  logic                 ACLK,
   input  logic                 ARESETn,
   // write address
   input  axi_mem_pkg::axi_ax_t aw,
   input  logic                 aw_valid,
   output logic                 aw_ready,
   // write data
   input  axi_mem_pkg::axi_w_t  w,
   input  logic                 w_valid,
   output logic                 w_ready,
   // write response
   output axi_mem_pkg::axi_b_t  b,
   output logic                 b_valid,
   input  logic                 b_ready,
   // read address
   input  axi_mem_pkg::axi_ax_t ar,
   input  logic                 ar_valid,
   output logic                 ar_ready,
   // read data
   output axi_mem_pkg::axi_r_t  r,
   output logic                 r_valid,
   input  logic                 r_ready
);

   // ----------------------------------------------------------
   // internal wires
   // ----------------------------------------------------------
   logic                        wq_valid, wq_ready;   // write queue pop side
   axi_mem_pkg::axi_ax_t        wq_data;
   logic                        rq_valid, rq_ready;   // read queue pop side
   axi_mem_pkg::axi_ax_t        rq_data;
   logic                        wr_en;
   logic [`AXI_MEM_INDEX_W-1:0] wr_index;
   logic [`AXI_MEM_STRB_W-1:0]  wr_strb;
   logic [`AXI_MEM_DATA_W-1:0]  wr_data;
   logic                        rd_en;
   logic [`AXI_MEM_INDEX_W-1:0] rd_index;
   logic [`AXI_MEM_DATA_W-1:0]  rd_data;

   axi_mem_req_fifo u_wr_queue (
      .ACLK, .ARESETn,
      .push_valid (aw_valid), .push_ready (aw_ready), .push_data (aw),
      .pop_valid  (wq_valid), .pop_ready  (wq_ready), .pop_data  (wq_data)
   );

   axi_mem_req_fifo u_rd_queue (
      .ACLK, .ARESETn,
      .push_valid (ar_valid), .push_ready (ar_ready), .push_data (ar),
      .pop_valid  (rq_valid), .pop_ready  (rq_ready), .pop_data  (rq_data)
   );

   axi_mem_write_engine u_write (
      .ACLK, .ARESETn,
      .req_valid (wq_valid), .req_ready (wq_ready), .req (wq_data),
      .w, .w_valid, .w_ready,
      .b, .b_valid, .b_ready,
      .mem_wr_en (wr_en), .mem_wr_index (wr_index),
      .mem_wr_strb (wr_strb), .mem_wr_data (wr_data)
   );

   axi_mem_read_engine u_read (
      .ACLK, .ARESETn,
      .req_valid (rq_valid), .req_ready (rq_ready), .req (rq_data),
      .r, .r_valid, .r_ready,
      .mem_rd_en (rd_en), .mem_rd_index (rd_index), .mem_rd_data (rd_data)
   );

   axi_mem_array u_array (
      .ACLK,
      .wr_en, .wr_index, .wr_strb, .wr_data,
      .rd_en, .rd_index, .rd_data
   );

endmodule

//--- hw/axi_mem_read_engine.sv
`timescale 1ns/1ps
`include "axi_mem_macros.svh"

// read burst FSM: pop AR, fetch one word per beat, send on R
module axi_mem_read_engine (
   input  logic                          ACLK,
   input  logic                          ARESETn,
   // queued AR request
   input  logic                          req_valid,
   output logic                          req_ready,
   input  axi_mem_pkg::axi_ax_t          req,
   // R channel
   output axi_mem_pkg::axi_r_t           r,
   output logic                          r_valid,
   input  logic                          r_ready,
   // array read port
   output logic                          mem_rd_en,
   output logic [`AXI_MEM_INDEX_W-1:0]   mem_rd_index,
   input  logic [`AXI_MEM_DATA_W-1:0]    mem_rd_data
);

   axi_mem_pkg::rd_state_e     state_q;
   logic [`AXI_MEM_LEN_W-1:0]  beats_q;  // beats left after this one
   logic [`AXI_MEM_ID_W-1:0]   id_q;
   logic [`AXI_MEM_ADDR_W-1:0] addr_q;
   logic [`AXI_MEM_SIZE_W-1:0] size_q;
   logic [`AXI_MEM_ADDR_W-1:0] step;
   logic                       pop;
   logic                       beat;

   assign pop  = req_valid && req_ready;
   assign beat = r_valid && r_ready;
   assign step = {{(`AXI_MEM_ADDR_W-1){1'b0}}, 1'b1} << size_q;

   assign req_ready = (state_q == axi_mem_pkg::RD_IDLE);
   assign r_valid   = (state_q == axi_mem_pkg::RD_SEND);

   // fetch one word, it lands in the array output register
   assign mem_rd_en    = (state_q == axi_mem_pkg::RD_FETCH);
   assign mem_rd_index = addr_q[`AXI_MEM_LANE_BITS +: `AXI_MEM_INDEX_W];

   // beat is built from registers only, so it holds under back-pressure
   assign r = '{id:   id_q,
                data: mem_rd_data,
                resp: axi_mem_pkg::OKAY,
                last: (beats_q == '0)};

   // ----------------------------------------------------------
   // FSM and beat counter
   // ----------------------------------------------------------
   always_ff @(posedge ACLK or negedge ARESETn) begin
      if (!ARESETn) begin
         state_q <= axi_mem_pkg::RD_IDLE;
         beats_q <= '0;
      end else begin
         unique case (state_q)
            axi_mem_pkg::RD_IDLE: begin
               if (pop) begin
                  state_q <= axi_mem_pkg::RD_FETCH;
                  beats_q <= req.len;
               end
            end
            axi_mem_pkg::RD_FETCH: state_q <= axi_mem_pkg::RD_SEND;
            axi_mem_pkg::RD_SEND: begin
               if (beat) begin
                  if (beats_q == '0) begin
                     state_q <= axi_mem_pkg::RD_IDLE;  // burst done
                  end else begin
                     state_q <= axi_mem_pkg::RD_FETCH;
                     beats_q <= beats_q - 1'b1;
                  end
               end
            end
            default: state_q <= axi_mem_pkg::RD_IDLE;
         endcase
      end
   end

   // burst context
   always_ff @(posedge ACLK) begin
      if (pop) begin
         id_q   <= req.id;
         addr_q <= req.addr;
         size_q <= req.size;
      end else if (beat) begin
         addr_q <= addr_q + step;
      end
   end

   a_r_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
      (r_valid && !r_ready) |=> (r_valid && $stable(r)));

endmodule

//--- hw/axi_mem_write_engine.sv
`timescale 1ns/1ps
`include "axi_mem_macros.svh"

// write burst FSM: pop AW, take W beats into the array, answer on B
module axi_mem_write_engine (
   input  logic                          ACLK,
   input  logic                          ARESETn,
   // queued AW request
   input  logic                          req_valid,
   output logic                          req_ready,
   input  axi_mem_pkg::axi_ax_t          req,
   // W channel
   input  axi_mem_pkg::axi_w_t           w,
   input  logic                          w_valid,
   output logic                          w_ready,
   // B channel
   output axi_mem_pkg::axi_b_t           b,
   output logic                          b_valid,
   input  logic                          b_ready,
   // array write port
   output logic                          mem_wr_en,
   output logic [`AXI_MEM_INDEX_W-1:0]   mem_wr_index,
   output logic [`AXI_MEM_STRB_W-1:0]    mem_wr_strb,
   output logic [`AXI_MEM_DATA_W-1:0]    mem_wr_data
);

   axi_mem_pkg::wr_state_e     state_q;
   logic [`AXI_MEM_LEN_W-1:0]  beats_q;  // beats left after this one
   logic [`AXI_MEM_ID_W-1:0]   id_q;
   logic [`AXI_MEM_ADDR_W-1:0] addr_q;   // address of the current beat
   logic [`AXI_MEM_SIZE_W-1:0] size_q;
   logic [`AXI_MEM_ADDR_W-1:0] step;     // bytes per beat
   logic                       pop;
   logic                       beat;

   assign pop  = req_valid && req_ready;
   assign beat = w_valid && w_ready;
   assign step = {{(`AXI_MEM_ADDR_W-1){1'b0}}, 1'b1} << size_q;

   assign req_ready = (state_q == axi_mem_pkg::WR_IDLE);
   assign w_ready   = (state_q == axi_mem_pkg::WR_DATA);
   assign b_valid   = (state_q == axi_mem_pkg::WR_RESP);
   assign b         = '{id: id_q, resp: axi_mem_pkg::OKAY};

   // ----------------------------------------------------------
   // array write, same edge as the W transfer
   // ----------------------------------------------------------
   assign mem_wr_en    = beat;
   assign mem_wr_index = addr_q[`AXI_MEM_LANE_BITS +: `AXI_MEM_INDEX_W];  // upper bits wrap
   assign mem_wr_strb  = w.strb;  // master picks the lanes
   assign mem_wr_data  = w.data;

   // ----------------------------------------------------------
   // FSM and beat counter
   // ----------------------------------------------------------
   always_ff @(posedge ACLK or negedge ARESETn) begin
      if (!ARESETn) begin
         state_q <= axi_mem_pkg::WR_IDLE;
         beats_q <= '0;
      end else begin
         unique case (state_q)
            axi_mem_pkg::WR_IDLE: begin
               if (pop) begin
                  state_q <= axi_mem_pkg::WR_DATA;
                  beats_q <= req.len;
               end
            end
            axi_mem_pkg::WR_DATA: begin
               if (beat) begin
                  if (beats_q == '0) begin
                     state_q <= axi_mem_pkg::WR_RESP;  // last beat taken
                  end else begin
                     beats_q <= beats_q - 1'b1;
                  end
               end
            end
            axi_mem_pkg::WR_RESP: begin
               if (b_ready) state_q <= axi_mem_pkg::WR_IDLE;
            end
            default: state_q <= axi_mem_pkg::WR_IDLE;
         endcase
      end
   end

   // burst context
   always_ff @(posedge ACLK) begin
      if (pop) begin
         id_q   <= req.id;
         addr_q <= req.addr;
         size_q <= req.size;
      end else if (beat) begin
         addr_q <= addr_q + step;  // INCR only
      end
   end

   // WLAST from the master must match our own beat count
   a_wlast: assert property (@(posedge ACLK) disable iff (!ARESETn)
      beat |-> (w.last == (beats_q == '0)));

endmodule

//--- hw/axi_mem_array.sv
`timescale 1ns/1ps
`include "axi_mem_macros.svh"

// word-wide storage, byte-lane writes, one-cycle read
module axi_mem_array (
   input  logic                          ACLK,
   // write port, write engine only
   input  logic                          wr_en,
   input  logic [`AXI_MEM_INDEX_W-1:0]   wr_index,
   input  logic [`AXI_MEM_STRB_W-1:0]    wr_strb,
   input  logic [`AXI_MEM_DATA_W-1:0]    wr_data,
   // read port, read engine only
   input  logic                          rd_en,
   input  logic [`AXI_MEM_INDEX_W-1:0]   rd_index,
   output logic [`AXI_MEM_DATA_W-1:0]    rd_data
);

   localparam int WORDS = `AXI_MEM_BYTES >> `AXI_MEM_LANE_BITS;

   logic [`AXI_MEM_DATA_W-1:0] mem_q [WORDS];

   // ----------------------------------------------------------
   // write, each enabled lane on its own
   // ----------------------------------------------------------
   always_ff @(posedge ACLK) begin
      for (int lane = 0; lane < `AXI_MEM_STRB_W; lane++) begin
         if (wr_en && wr_strb[lane]) begin
            mem_q[wr_index][8*lane +: 8] <= wr_data[8*lane +: 8];
         end
      end
   end

   // registered read port, maps onto block RAM
   always_ff @(posedge ACLK) begin
      if (rd_en) begin
         rd_data <= mem_q[rd_index];  // held until the next rd_en
      end
   end

endmodule

//--- hw/axi_mem_req_fifo.sv
`timescale 1ns/1ps
`include "axi_mem_macros.svh"

// first-word fall-through queue for AW / AR requests
module axi_mem_req_fifo #(
   parameter int DEPTH_LOG = `AXI_MEM_QUEUE_LOG
) (
   input  logic                 ACLK,
   input  logic                 ARESETn,
   // push side, from the address channel
   input  logic                 push_valid,
   output logic                 push_ready,
   input  axi_mem_pkg::axi_ax_t push_data,
   // pop side, to an engine
   output logic                 pop_valid,
   input  logic                 pop_ready,
   output axi_mem_pkg::axi_ax_t pop_data
);

   localparam int DEPTH = 1 << DEPTH_LOG;

   axi_mem_pkg::axi_ax_t slot_q [DEPTH];  // request storage
   logic [DEPTH_LOG:0]   head_q;          // extra msb tells full from empty
   logic [DEPTH_LOG:0]   tail_q;
   logic                 full;
   logic                 empty;
   logic                 push;
   logic                 pop;

   assign empty = (head_q == tail_q);
   assign full  = (head_q[DEPTH_LOG] != tail_q[DEPTH_LOG]) &&
                  (head_q[DEPTH_LOG-1:0] == tail_q[DEPTH_LOG-1:0]);

   assign push_ready = !full;  // independent of push_valid
   assign pop_valid  = !empty;
   assign push = push_valid && push_ready;
   assign pop  = pop_ready && !empty;

   assign pop_data = slot_q[head_q[DEPTH_LOG-1:0]];  // fall-through read

   // ----------------------------------------------------------
   // pointers
   // ----------------------------------------------------------
   always_ff @(posedge ACLK or negedge ARESETn) begin
      if (!ARESETn) begin
         head_q <= '0;
         tail_q <= '0;
      end else begin
         if (push) tail_q <= tail_q + 1'b1;
         if (pop)  head_q <= head_q + 1'b1;
      end
   end

   always_ff @(posedge ACLK) begin
      if (push) slot_q[tail_q[DEPTH_LOG-1:0]] <= push_data;
   end

   // a request refused while full stays offered unchanged
   a_push_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
      (push_valid && full) |=> (push_valid && $stable(push_data)));

   // head entry must not move under a waiting engine
   a_head_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
      (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_data)));

endmodule

//--- hw/axi_mem_pkg.sv
`include "axi_mem_macros.svh"

package axi_mem_pkg;

   // ----------------------------------------------------------
   // response codes, only OKAY leaves this slave
   // ----------------------------------------------------------
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   // ----------------------------------------------------------
   // channel payloads
   // ----------------------------------------------------------
   typedef struct packed {
      logic [`AXI_MEM_ID_W-1:0]   id;
      logic [`AXI_MEM_ADDR_W-1:0] addr;
      logic [`AXI_MEM_LEN_W-1:0]  len;   // beats minus one
      logic [`AXI_MEM_SIZE_W-1:0] size;  // log2 bytes per beat
   } axi_ax_t;  // shared by AW and AR

   typedef struct packed {
      logic [`AXI_MEM_DATA_W-1:0] data;
      logic [`AXI_MEM_STRB_W-1:0] strb;
      logic                       last;
   } axi_w_t;

   typedef struct packed {
      logic [`AXI_MEM_ID_W-1:0] id;
      axi_resp_e                resp;
   } axi_b_t;

   typedef struct packed {
      logic [`AXI_MEM_ID_W-1:0]   id;
      logic [`AXI_MEM_DATA_W-1:0] data;
      axi_resp_e                  resp;
      logic                       last;
   } axi_r_t;

   // engine states
   typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;
   typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_SEND} rd_state_e;

endpackage

//--- hw/axi_mem_macros.svh
`ifndef AXI_MEM_MACROS_SVH
`define AXI_MEM_MACROS_SVH

// ----------------------------------------------------------
// channel field widths
// ----------------------------------------------------------
`define AXI_MEM_ID_W      8   // channel id and id joined
`define AXI_MEM_ADDR_W    32
`define AXI_MEM_DATA_W    32
`define AXI_MEM_STRB_W    (`AXI_MEM_DATA_W/8)  // one strobe per byte lane
`define AXI_MEM_LEN_W     8   // AXI4 burst length
`define AXI_MEM_SIZE_W    3

// ----------------------------------------------------------
// storage geometry
// ----------------------------------------------------------
`define AXI_MEM_BYTES     1024
`define AXI_MEM_LANE_BITS 2   // byte offset inside a word
`define AXI_MEM_INDEX_W   8   // 256 words of 4 bytes

// request queue depth, as log2
`define AXI_MEM_QUEUE_LOG 4

`endif
